// ==== design/mont_pkg.sv ====
`default_nettype none

package mont_pkg;

  // Operand geometry for the word-array multiplier
  localparam int WRD_BITS = 16;
  localparam int NUM_WRDS = 4;
  localparam int DAT_BITS = WRD_BITS * NUM_WRDS;

  typedef logic [DAT_BITS-1:0]   dat_t;
  typedef logic [2*DAT_BITS-1:0] wide_t;
  typedef logic [31:0]           iter_t;
  typedef logic [31:0]           axil_data_t;
  typedef logic [7:0]            axil_addr_t;

  // Multiplier modes, one-hot
  typedef enum logic [2:0] {
    SQR   = 3'b001,
    MUL_L = 3'b010,
    MUL_H = 3'b100
  } mult_ctl_t;

  // Core sequencer states, one-hot
  typedef enum logic [5:0] {
    IDLE     = 6'b000001,
    SQR_STEP = 6'b000010,
    RED_LO   = 6'b000100,
    RED_HI   = 6'b001000,
    FIX      = 6'b010000,
    DONE     = 6'b100000
  } sqr_state_t;

  // Register offsets on the AXI4-Lite slave
  typedef enum logic [7:0] {
    CTRL    = 8'h00,
    STATUS  = 8'h04,
    OPND_LO = 8'h08,
    OPND_HI = 8'h0C,
    ITER    = 8'h10,
    RES_LO  = 8'h14,
    RES_HI  = 8'h18
  } reg_addr_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_t;

  // Returns -p^-1 mod 2^64 for an odd p
  // Newton steps double the number of correct low bits, starting from 3
  function automatic dat_t mont_factor(input dat_t p);
    dat_t inv;
    inv = p;
    for (int i = 0; i < 5; i++) begin
      inv = inv * (64'd2 - p * inv);
    end
    return -inv;
  endfunction

endpackage

`default_nettype wire

// ==== design/mont_ctl_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// Command and status path between the register block and the core
interface mont_ctl_if;
  import mont_pkg::*;

  // One-cycle start command from the register block
  logic  start;
  // Held stable while start is high and while the core is busy
  dat_t  operand;
  iter_t iter_count;

  // Busy from the core spans the whole run including the done cycle
  logic  busy;
  logic  done_pulse;
  dat_t  result;

  modport host (
    output start, operand, iter_count,
    input  busy, done_pulse, result
  );

  modport core (
    input  start, operand, iter_count,
    output busy, done_pulse, result
  );

endinterface

`default_nettype wire

// ==== design/multi_mode_multiplier.sv ====
`timescale 1ns/10ps
`default_nettype none

module multi_mode_multiplier (
  input  logic                i_clk,
  input  mont_pkg::mult_ctl_t i_ctl,
  input  mont_pkg::dat_t      i_dat_a,
  input  mont_pkg::dat_t      i_dat_b,
  input  mont_pkg::dat_t      i_add_term,
  input  logic                i_add_carry,
  output mont_pkg::wide_t     o_dat
);
  import mont_pkg::*;

  logic [WRD_BITS-1:0]   a_w [NUM_WRDS];
  logic [WRD_BITS-1:0]   b_w [NUM_WRDS];
  logic [2*WRD_BITS-1:0] pp  [NUM_WRDS][NUM_WRDS];
  wide_t                 prod;

  // Split the operands into words and form every word product
  // When squaring, the b side just mirrors a
  always_comb begin
    for (int i = 0; i < NUM_WRDS; i++) begin
      a_w[i] = i_dat_a[i*WRD_BITS +: WRD_BITS];
      b_w[i] = (i_ctl == SQR) ? i_dat_a[i*WRD_BITS +: WRD_BITS]
                              : i_dat_b[i*WRD_BITS +: WRD_BITS];
    end
    for (int i = 0; i < NUM_WRDS; i++) begin
      for (int j = 0; j < NUM_WRDS; j++) begin
        pp[i][j] = a_w[i] * b_w[j];
      end
    end
  end

  // Accumulate the partial products with full carry propagation
  // A square only needs the diagonal plus the upper triangle doubled
  always_comb begin
    prod = '0;
    for (int i = 0; i < NUM_WRDS; i++) begin
      for (int j = 0; j < NUM_WRDS; j++) begin
        if (i_ctl != SQR) begin
          prod = prod + (wide_t'(pp[i][j]) << (WRD_BITS * (i + j)));
        end else if (i == j) begin
          prod = prod + (wide_t'(pp[i][j]) << (2 * WRD_BITS * i));
        end else if (i < j) begin
          prod = prod + (wide_t'(pp[i][j]) << (WRD_BITS * (i + j) + 1));
        end
      end
    end
  end

  // One cycle of latency from inputs to product
  always_ff @(posedge i_clk) begin
    case (i_ctl)
      MUL_L: o_dat <= {{DAT_BITS{1'b0}}, prod[DAT_BITS-1:0]};
      // Upper product lands in the low half, carry out of the add in bit 64
      MUL_H: o_dat <= wide_t'(prod[2*DAT_BITS-1:DAT_BITS]) + wide_t'(i_add_term)
                      + wide_t'(i_add_carry);
      default: o_dat <= prod;
    endcase
  end

  a_ctl_onehot: assert property (@(posedge i_clk) $onehot(i_ctl))
    else $error("multiplier mode is not one-hot");

endmodule

`default_nettype wire

// ==== design/mont_sqr_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module mont_sqr_core #(
  parameter mont_pkg::dat_t MODULUS = 64'h7FFF_FFFF_FFFF_FFE7
) (
  input logic      i_clk,
  input logic      i_rst,
  mont_ctl_if.core ctl
);
  import mont_pkg::*;

  // -P^-1 mod R, used to clear the low half of T
  localparam dat_t M_FACTOR = mont_factor(MODULUS);

  sqr_state_t        state;
  iter_t             count;
  dat_t              x_q;
  dat_t              t_hi_q;
  logic              t_lo_nz_q;

  mult_ctl_t         mul_ctl;
  dat_t              mul_a;
  dat_t              mul_b;
  wide_t             mul_out;

  logic [DAT_BITS:0] fix_sum;
  logic [DAT_BITS:0] fix_diff;
  dat_t              fix_val;

  // Multiplier input select follows the current state
  // The product of each step arrives in the following state
  always_comb begin
    mul_ctl = SQR;
    mul_a   = x_q;
    mul_b   = x_q;
    case (state)
      RED_LO: begin
        // m = T_lo * factor mod R
        mul_ctl = MUL_L;
        mul_a   = mul_out[DAT_BITS-1:0];
        mul_b   = M_FACTOR;
      end
      RED_HI: begin
        // (m * P)_hi + T_hi + carry from the low halves
        mul_ctl = MUL_H;
        mul_a   = mul_out[DAT_BITS-1:0];
        mul_b   = MODULUS;
      end
      default: begin
        mul_ctl = SQR;
      end
    endcase
  end

  // The reduced value is below 2P, so one subtraction is enough
  assign fix_sum  = mul_out[DAT_BITS:0];
  assign fix_diff = fix_sum - {1'b0, MODULUS};
  assign fix_val  = fix_diff[DAT_BITS] ? fix_sum[DAT_BITS-1:0] : fix_diff[DAT_BITS-1:0];

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (ctl.start) begin
            count <= ctl.iter_count;
            state <= (ctl.iter_count == '0) ? DONE : SQR_STEP;
          end
        end
        SQR_STEP: state <= RED_LO;
        RED_LO:   state <= RED_HI;
        RED_HI:   state <= FIX;
        FIX: begin
          count <= count - 1'b1;
          state <= (count == iter_t'(1)) ? DONE : SQR_STEP;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == IDLE && ctl.start) begin
      x_q <= ctl.operand;
    end
    // Keep the upper half of T and whether its low half adds a carry
    if (state == RED_LO) begin
      t_hi_q    <= mul_out[2*DAT_BITS-1:DAT_BITS];
      t_lo_nz_q <= |mul_out[DAT_BITS-1:0];
    end
    if (state == FIX) begin
      x_q <= fix_val;
    end
  end

  assign ctl.busy       = (state != IDLE);
  assign ctl.done_pulse = (state == DONE);
  assign ctl.result     = x_q;

  multi_mode_multiplier i_multi_mode_multiplier (
    .i_clk       (i_clk),
    .i_ctl       (mul_ctl),
    .i_dat_a     (mul_a),
    .i_dat_b     (mul_b),
    .i_add_term  (t_hi_q),
    .i_add_carry (t_lo_nz_q),
    .o_dat       (mul_out)
  );

  a_state_onehot: assert property (@(posedge i_clk) disable iff (i_rst) $onehot(state))
    else $error("core state is not one-hot");

  // The register block must hold back a start while a run is in flight
  a_no_start_busy: assert property (@(posedge i_clk) disable iff (i_rst)
    ctl.busy |-> !ctl.start)
    else $error("start arrived while busy");

  a_result_reduced: assert property (@(posedge i_clk) disable iff (i_rst)
    ctl.done_pulse && $past(state == FIX) |-> ctl.result < MODULUS)
    else $error("result not reduced below the modulus");

endmodule

`default_nettype wire

// ==== design/mont_axil_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module mont_axil_regs (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_awvalid,
  output logic                 o_awready,
  input  mont_pkg::axil_addr_t i_awaddr,
  input  logic                 i_wvalid,
  output logic                 o_wready,
  input  mont_pkg::axil_data_t i_wdata,
  input  logic [3:0]           i_wstrb,
  output logic                 o_bvalid,
  input  logic                 i_bready,
  output mont_pkg::axil_resp_t o_bresp,
  input  logic                 i_arvalid,
  output logic                 o_arready,
  input  mont_pkg::axil_addr_t i_araddr,
  output logic                 o_rvalid,
  input  logic                 i_rready,
  output mont_pkg::axil_data_t o_rdata,
  output mont_pkg::axil_resp_t o_rresp,
  mont_ctl_if.host             ctl
);
  import mont_pkg::*;

  dat_t       opnd_q;
  iter_t      iter_q;
  dat_t       res_q;
  logic       done_q;
  reg_addr_t  wr_addr;
  reg_addr_t  rd_addr;
  logic       wr_en;
  logic       rd_en;
  logic       wr_err;
  logic       rd_err;
  logic       start_req;
  axil_data_t rd_word;

  assign wr_addr = reg_addr_t'(i_awaddr);
  assign rd_addr = reg_addr_t'(i_araddr);
  assign wr_en   = o_awready & i_awvalid & i_wvalid;
  assign rd_en   = o_arready & i_arvalid;

  // Operand and count are locked while the core runs
  always_comb begin
    wr_err    = 1'b0;
    start_req = 1'b0;
    case (wr_addr)
      CTRL:                   start_req = i_wstrb[0] & i_wdata[0] & ~ctl.busy;
      STATUS, RES_LO, RES_HI: wr_err = 1'b0;
      OPND_LO, OPND_HI, ITER: wr_err = ctl.busy;
      default:                wr_err = 1'b1;
    endcase
  end

  always_comb begin
    rd_word = '0;
    rd_err  = 1'b0;
    case (rd_addr)
      CTRL:    rd_word = '0;
      STATUS:  rd_word = {30'd0, done_q, ctl.busy};
      OPND_LO: rd_word = opnd_q[31:0];
      OPND_HI: rd_word = opnd_q[63:32];
      ITER:    rd_word = iter_q;
      RES_LO:  rd_word = res_q[31:0];
      RES_HI:  rd_word = res_q[63:32];
      default: rd_err = 1'b1;
    endcase
  end

  // Ready pulses for one cycle, and never while a response is still pending
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      o_awready <= 1'b0;
      o_wready  <= 1'b0;
      o_bvalid  <= 1'b0;
      o_arready <= 1'b0;
      o_rvalid  <= 1'b0;
      ctl.start <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      o_awready <= i_awvalid & i_wvalid & ~o_awready & ~o_bvalid;
      o_wready  <= i_awvalid & i_wvalid & ~o_awready & ~o_bvalid;
      o_arready <= i_arvalid & ~o_arready & ~o_rvalid;
      ctl.start <= wr_en & start_req;
      if (wr_en) begin
        o_bvalid <= 1'b1;
      end else if (i_bready) begin
        o_bvalid <= 1'b0;
      end
      if (rd_en) begin
        o_rvalid <= 1'b1;
      end else if (i_rready) begin
        o_rvalid <= 1'b0;
      end
      // Done stays set until the next run is launched
      if (ctl.done_pulse) begin
        done_q <= 1'b1;
      end else if (ctl.start) begin
        done_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (wr_en) begin
      o_bresp <= wr_err ? SLVERR : OKAY;
    end
    if (rd_en) begin
      o_rdata <= rd_word;
      o_rresp <= rd_err ? SLVERR : OKAY;
    end
    for (int b = 0; b < 4; b++) begin
      if (wr_en && !wr_err && i_wstrb[b]) begin
        case (wr_addr)
          OPND_LO: opnd_q[8*b +: 8]      <= i_wdata[8*b +: 8];
          OPND_HI: opnd_q[32 + 8*b +: 8] <= i_wdata[8*b +: 8];
          ITER:    iter_q[8*b +: 8]      <= i_wdata[8*b +: 8];
          default: ;
        endcase
      end
    end
    if (ctl.done_pulse) begin
      res_q <= ctl.result;
    end
  end

  assign ctl.operand    = opnd_q;
  assign ctl.iter_count = iter_q;

  a_bvalid_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp))
    else $error("write response dropped before bready");

  a_rvalid_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata) && $stable(o_rresp))
    else $error("read response dropped before rready");

endmodule

`default_nettype wire

// ==== design/mont_sqr_top.sv ====
`timescale 1ns/10ps
`default_nettype none

// Repeated Montgomery squaring behind an AXI4-Lite register slave
module mont_sqr_top #(
  // Largest 63-bit prime, 2^63 - 25
  parameter mont_pkg::dat_t MODULUS = 64'h7FFF_FFFF_FFFF_FFE7
) (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_awvalid,
  output logic                 o_awready,
  input  mont_pkg::axil_addr_t i_awaddr,
  input  logic                 i_wvalid,
  output logic                 o_wready,
  input  mont_pkg::axil_data_t i_wdata,
  input  logic [3:0]           i_wstrb,
  output logic                 o_bvalid,
  input  logic                 i_bready,
  output mont_pkg::axil_resp_t o_bresp,
  input  logic                 i_arvalid,
  output logic                 o_arready,
  input  mont_pkg::axil_addr_t i_araddr,
  output logic                 o_rvalid,
  input  logic                 i_rready,
  output mont_pkg::axil_data_t o_rdata,
  output mont_pkg::axil_resp_t o_rresp
);

  mont_ctl_if i_ctl_if ();

  mont_axil_regs i_mont_axil_regs (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_awaddr  (i_awaddr),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .i_wdata   (i_wdata),
    .i_wstrb   (i_wstrb),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_bresp   (o_bresp),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .i_araddr  (i_araddr),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .o_rdata   (o_rdata),
    .o_rresp   (o_rresp),
    .ctl       (i_ctl_if.host)
  );

  mont_sqr_core #(
    .MODULUS (MODULUS)
  ) i_mont_sqr_core (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .ctl   (i_ctl_if.core)
  );

endmodule

`default_nettype wire

// ==== verification/mont_sqr_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module mont_sqr_tb;
  import mont_pkg::*;

  localparam dat_t MODULUS   = 64'h7FFF_FFFF_FFFF_FFE7;
  localparam int   NUM_RAND  = 20;
  localparam int   BUSY_ITER = 8;

  logic       clk;
  logic       rst;
  logic       awvalid;
  logic       awready;
  axil_addr_t awaddr;
  logic       wvalid;
  logic       wready;
  axil_data_t wdata;
  logic [3:0] wstrb;
  logic       bvalid;
  logic       bready;
  axil_resp_t bresp;
  logic       arvalid;
  logic       arready;
  axil_addr_t araddr;
  logic       rvalid;
  logic       rready;
  axil_data_t rdata;
  axil_resp_t rresp;

  int         errors;
  int         checks;
  int         budget_cycles;
  dat_t       rand_opnd [NUM_RAND];
  iter_t      rand_iter [NUM_RAND];
  dat_t       single_opnd;

  mont_sqr_top #(
    .MODULUS (MODULUS)
  ) i_mont_sqr_top (
    .i_clk     (clk),
    .i_rst     (rst),
    .i_awvalid (awvalid),
    .o_awready (awready),
    .i_awaddr  (awaddr),
    .i_wvalid  (wvalid),
    .o_wready  (wready),
    .i_wdata   (wdata),
    .i_wstrb   (wstrb),
    .o_bvalid  (bvalid),
    .i_bready  (bready),
    .o_bresp   (bresp),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .i_araddr  (araddr),
    .o_rvalid  (rvalid),
    .i_rready  (rready),
    .o_rdata   (rdata),
    .o_rresp   (rresp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Ends a run that has stalled somewhere
  initial begin
    wait (budget_cycles > 0);
    repeat (budget_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles with tests still running", budget_cycles);
    $display("Test failed");
    $finish;
  end

  task automatic check_dat(input string name, input dat_t got, input dat_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input axil_resp_t got, input axil_resp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input axil_data_t got, input axil_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // Every bus task starts and ends 1 ns after a rising edge
  task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                            input logic [3:0] strb, input axil_resp_t exp_resp,
                            input int stall);
    axil_resp_t first;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(posedge clk);
    #1;
    while (!awready) begin
      @(posedge clk);
      #1;
    end
    checks++;
    if (wready !== 1'b1) begin
      errors++;
      $display("Write at 0x%h saw awready without wready in the same cycle", addr);
    end
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) begin
      @(posedge clk);
      #1;
    end
    first = bresp;
    for (int i = 0; i < stall; i++) begin
      @(posedge clk);
      #1;
      if (!bvalid) begin
        errors++;
        $display("Write response at 0x%h was withdrawn before bready was raised", addr);
      end
      check_resp("bresp (held)", bresp, first);
    end
    check_resp("bresp", first, exp_resp);
    bready = 1'b1;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic axil_read(input axil_addr_t addr, input axil_resp_t exp_resp,
                           input int stall, output axil_data_t data);
    axil_resp_t first_resp;
    araddr  = addr;
    arvalid = 1'b1;
    @(posedge clk);
    #1;
    while (!arready) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    while (!rvalid) begin
      @(posedge clk);
      #1;
    end
    data       = rdata;
    first_resp = rresp;
    for (int i = 0; i < stall; i++) begin
      @(posedge clk);
      #1;
      if (!rvalid) begin
        errors++;
        $display("Read response at 0x%h was withdrawn before rready was raised", addr);
      end
      check_word("rdata (held)", rdata, data);
      check_resp("rresp (held)", rresp, first_resp);
    end
    check_resp("rresp", first_resp, exp_resp);
    rready = 1'b1;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  // x <- x*x*R^-1 mod P, where R^-1 = (1 + P*factor) / R since P*factor = -1 mod R
  function automatic dat_t mont_sqr_ref(input dat_t x, input iter_t n);
    wide_t r_inv;
    wide_t acc;
    dat_t  v;
    r_inv = (wide_t'(1) + wide_t'(MODULUS) * wide_t'(mont_factor(MODULUS))) >> DAT_BITS;
    v     = x;
    for (int i = 0; i < int'(n); i++) begin
      acc = (wide_t'(v) * wide_t'(v)) % wide_t'(MODULUS);
      acc = (acc * r_inv) % wide_t'(MODULUS);
      v   = acc[DAT_BITS-1:0];
    end
    return v;
  endfunction

  function automatic int run_cycles(input iter_t n);
    return 4 * int'(n) + 40;
  endfunction

  task automatic start_run(input dat_t x, input iter_t n);
    axil_data_t status;
    axil_write(OPND_LO, x[31:0], 4'hF, OKAY, 0);
    axil_write(OPND_HI, x[63:32], 4'hF, OKAY, 0);
    axil_write(ITER, n, 4'hF, OKAY, 0);
    axil_write(CTRL, 32'h1, 4'hF, OKAY, 0);
    // A fresh start clears the sticky done bit
    if (n != 0) begin
      axil_read(STATUS, OKAY, 0, status);
      check_word("status after start", status, 32'h1);
    end
  endtask

  task automatic wait_done();
    axil_data_t status;
    status = '0;
    while (!status[1]) begin
      axil_read(STATUS, OKAY, 0, status);
    end
  endtask

  task automatic check_result(input dat_t exp);
    axil_data_t lo;
    axil_data_t hi;
    axil_read(RES_LO, OKAY, 0, lo);
    axil_read(RES_HI, OKAY, 0, hi);
    check_dat("result", {hi, lo}, exp);
  endtask

  task automatic test_register_readback();
    axil_data_t w;
    axil_write(OPND_LO, 32'h1234_5678, 4'hF, OKAY, 0);
    axil_write(OPND_HI, 32'h9ABC_DEF0, 4'hF, OKAY, 0);
    axil_write(ITER, 32'h0000_0005, 4'hF, OKAY, 0);
    axil_read(OPND_LO, OKAY, 0, w);
    check_word("opnd_lo", w, 32'h1234_5678);
    axil_read(OPND_HI, OKAY, 0, w);
    check_word("opnd_hi", w, 32'h9ABC_DEF0);
    axil_read(ITER, OKAY, 0, w);
    check_word("iter", w, 32'h0000_0005);
    // Bytes 0 and 2 only
    axil_write(OPND_LO, 32'hAABB_CCDD, 4'b0101, OKAY, 0);
    axil_read(OPND_LO, OKAY, 0, w);
    check_word("opnd_lo strobed", w, 32'h12BB_56DD);
  endtask

  task automatic test_single_squaring();
    dat_t vals [4];
    vals[0] = single_opnd;
    vals[1] = '0;
    vals[2] = 64'd1;
    vals[3] = MODULUS - 64'd1;
    for (int i = 0; i < 4; i++) begin
      start_run(vals[i], 32'd1);
      wait_done();
      check_result(mont_sqr_ref(vals[i], 32'd1));
    end
  endtask

  task automatic test_repeated_squaring();
    for (int i = 0; i < NUM_RAND; i++) begin
      start_run(rand_opnd[i], rand_iter[i]);
      wait_done();
      check_result(mont_sqr_ref(rand_opnd[i], rand_iter[i]));
    end
  endtask

  task automatic test_zero_count();
    start_run(64'hFEDC_BA98_7654_3210, 32'd0);
    wait_done();
    check_result(64'hFEDC_BA98_7654_3210);
  endtask

  task automatic test_bus_errors();
    axil_data_t w;
    axil_read(8'h20, SLVERR, 0, w);
    check_word("unmapped rdata", w, 32'h0);
    axil_write(8'h3C, 32'hFFFF_FFFF, 4'hF, SLVERR, 0);
    axil_write(ITER, 32'h0000_0033, 4'hF, OKAY, 5);
    axil_read(ITER, OKAY, 6, w);
    check_word("iter after stall", w, 32'h0000_0033);
  endtask

  task automatic test_busy_protection();
    axil_data_t w;
    dat_t       x;
    x = 64'h0123_4567_89AB_CDEF;
    start_run(x, BUSY_ITER);
    axil_write(OPND_LO, 32'hDEAD_BEEF, 4'hF, SLVERR, 0);
    axil_write(CTRL, 32'h1, 4'hF, OKAY, 0);
    axil_read(OPND_LO, OKAY, 0, w);
    check_word("opnd_lo while busy", w, x[31:0]);
    wait_done();
    check_result(mont_sqr_ref(x, BUSY_ITER));
  endtask

  initial begin
    rst     = 1'b1;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    errors  = 0;
    checks  = 0;
    budget_cycles = 0;

    void'($urandom(38270));
    single_opnd = {$urandom, $urandom} % MODULUS;
    for (int i = 0; i < NUM_RAND; i++) begin
      rand_opnd[i] = {$urandom, $urandom} % MODULUS;
      rand_iter[i] = ($urandom % 64) + 1;
    end

    // Readback and bus tests count as runs of zero iterations
    begin
      int total;
      total = 3 * run_cycles(0) + 4 * run_cycles(1) + run_cycles(BUSY_ITER);
      for (int i = 0; i < NUM_RAND; i++) begin
        total += run_cycles(rand_iter[i]);
      end
      budget_cycles = 2 * total;
    end

    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    check_dat("P * factor + 1", MODULUS * mont_factor(MODULUS) + 64'd1, 64'd0);
    test_register_readback();
    test_single_squaring();
    test_repeated_squaring();
    test_zero_count();
    test_bus_errors();
    test_busy_protection();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
design/mont_pkg.sv
design/mont_ctl_if.sv
design/multi_mode_multiplier.sv
design/mont_sqr_core.sv
design/mont_axil_regs.sv
design/mont_sqr_top.sv
verification/mont_sqr_tb.sv

// ==== Makefile ====
# Verilator flow for the Montgomery squaring accelerator

VERILATOR ?= verilator
TOP       ?= mont_sqr_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

# The log is searched for the pass line, so a crash or a failing run both fail here
sim: build
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -q "^Test passed$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
